// ==== neopixel_driver.f ====
neopixel_pkg.sv
ws2812_bit_encoder.sv
byte_serializer.sv
strip_controller.sv
spi_byte_receiver.sv
spi_command_decoder.sv
neopixel_driver.sv
neopixel_properties.sv
neopixel_driver_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the neopixel_driver testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module neopixel_driver_tb \
	-f neopixel_driver.f \
	-o neopixel_driver_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/neopixel_driver_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== neopixel_driver_tb.sv ====
`timescale 1ns/1ps

module neopixel_driver_tb
	import neopixel_pkg::*;
();

	localparam int NUM_STRIPS = 3;
	localparam int STRIP_BYTES = 4;
	localparam int LATCH_CYCLES = 100;
	localparam int PULSE_TIMEOUT = 2000;
	localparam int IDLE_TIMEOUT = 1000;

	logic clk;
	logic reset;
	logic sclk;
	logic mosi;
	logic cs;
	logic [NUM_STRIPS-1:0] pixels;
	logic flushing;

	// expected buffer contents and the bytes decoded from each pixel pin
	byte_t model [NUM_STRIPS][STRIP_BYTES];
	byte_t rx_bytes [NUM_STRIPS][STRIP_BYTES];
	logic [31:0] lfsr;
	int value_errors;
	int timeout_errors;
	int timing_errors;

	neopixel_driver #(
		.NUM_STRIPS  (NUM_STRIPS),
		.STRIP_BYTES (STRIP_BYTES),
		.LATCH_CYCLES(LATCH_CYCLES)
	) i_neopixel_driver (
		.clk     (clk),
		.reset   (reset),
		.sclk    (sclk),
		.mosi    (mosi),
		.cs      (cs),
		.pixels  (pixels),
		.flushing(flushing)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	function automatic int distance(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic random_byte(output byte_t value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %02h, actual %02h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	// MSB first with sclk toggling every four clk cycles
	task automatic send_bits(input byte_t value, input int count);
		for (int i = 7; i > 7 - count; i--) begin
			mosi = value[i];
			repeat (4) @(negedge clk);
			sclk = 1'b1;
			repeat (4) @(negedge clk);
			sclk = 1'b0;
		end
	endtask

	task automatic start_frame();
		cs = 1'b1;
		repeat (4) @(negedge clk);
	endtask

	// the last byte reaches the decoder well before cs drops
	task automatic end_frame();
		repeat (8) @(negedge clk);
		cs = 1'b0;
		repeat (8) @(negedge clk);
	endtask

	task automatic send_frame(input byte_t frame[$]);
		start_frame();
		foreach (frame[i])
			send_bits(frame[i], 8);
		end_frame();
	endtask

	task automatic send_command(input byte_t cmd);
		start_frame();
		send_bits(cmd, 8);
		end_frame();
	endtask

	task automatic write_strip(input int strip, input int offset, input byte_t data[$]);
		byte_t frame[$];
		frame.push_back(byte_t'(strip));
		frame.push_back(byte_t'(offset));
		foreach (data[i]) begin
			frame.push_back(data[i]);
			if (offset + i < STRIP_BYTES)
				model[strip][offset + i] = data[i];
		end
		send_frame(frame);
	endtask

	// decodes STRIP_BYTES bytes LSB first from one pixel pin
	task automatic capture_stream(input int strip);
		int count;
		int width;
		byte_t value;
		for (int n = 0; n < STRIP_BYTES; n++) begin
			value = '0;
			for (int i = 0; i < 8; i++) begin
				count = 0;
				while (pixels[strip] !== 1'b1 && count < PULSE_TIMEOUT) begin
					@(negedge clk);
					count++;
				end
				if (pixels[strip] !== 1'b1) begin
					$display("timeout: no pulse on strip %0d for byte %0d bit %0d", strip, n, i);
					timeout_errors++;
					return;
				end
				width = 0;
				while (pixels[strip] === 1'b1 && width <= BIT_CYCLES) begin
					@(negedge clk);
					width++;
				end
				if (width > BIT_CYCLES) begin
					$display("timeout: pulse on strip %0d never ended", strip);
					timeout_errors++;
					return;
				end
				value[i] = distance(width, T1_HIGH) < distance(width, T0_HIGH);
			end
			rx_bytes[strip][n] = value;
		end
	endtask

	task automatic wait_flush_done(output int cycles);
		cycles = 0;
		while (flushing !== 1'b0 && cycles < IDLE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (flushing !== 1'b0) begin
			$display("timeout: flushing did not fall within %0d cycles", IDLE_TIMEOUT);
			timeout_errors++;
		end
	endtask

	task automatic flush_and_compare(input string name);
		int gap;
		for (int s = 0; s < NUM_STRIPS; s++)
			for (int n = 0; n < STRIP_BYTES; n++)
				rx_bytes[s][n] = '0;
		fork
			capture_stream(0);
			capture_stream(1);
			capture_stream(2);
			send_command(CMD_FLUSH);
		join
		// latch gap is still running here
		check_level({name, " flushing"}, 1'b1, flushing);
		wait_flush_done(gap);
		// rest of the last slot plus the latch gap
		if (gap < LATCH_CYCLES || gap > BIT_CYCLES + LATCH_CYCLES) begin
			$display("%s: flushing fell %0d cycles after the last pulse, not after a latch gap",
				name, gap);
			timing_errors++;
		end
		for (int s = 0; s < NUM_STRIPS; s++)
			for (int n = 0; n < STRIP_BYTES; n++)
				check_byte($sformatf("%s strip %0d byte %0d", name, s, n),
					model[s][n], rx_bytes[s][n]);
	endtask

	task automatic reset_state();
		logic seen;
		seen = 1'b0;
		check_level("reset flushing", 1'b0, flushing);
		for (int s = 0; s < NUM_STRIPS; s++)
			check_level($sformatf("reset pixel %0d", s), 1'b0, pixels[s]);
		repeat (200) begin
			@(negedge clk);
			seen = seen | (|pixels) | flushing;
		end
		check_level("idle activity", 1'b0, seen);
	endtask

	task automatic write_and_flush();
		byte_t data[$];
		byte_t b;
		for (int s = 0; s < NUM_STRIPS; s++) begin
			data.delete();
			for (int n = 0; n < STRIP_BYTES; n++) begin
				random_byte(b);
				data.push_back(b);
			end
			write_strip(s, 0, data);
		end
		flush_and_compare("write and flush");
	endtask

	task automatic offset_increment();
		byte_t data[$];
		byte_t b;
		for (int n = 0; n < 2; n++) begin
			random_byte(b);
			data.push_back(b);
		end
		write_strip(1, 2, data);
		flush_and_compare("offset");
	endtask

	// the bytes after the unknown command would form a write to strip 0
	task automatic invalid_command();
		byte_t frame[$];
		byte_t b;
		frame.push_back(8'h50);
		frame.push_back(8'h00);
		frame.push_back(8'h00);
		for (int n = 0; n < 2; n++) begin
			random_byte(b);
			frame.push_back(b);
		end
		send_frame(frame);
		flush_and_compare("invalid command");
	endtask

	// cs drops halfway through the second data byte
	task automatic aborted_frame();
		byte_t first;
		byte_t partial;
		byte_t data[$];
		byte_t b;
		random_byte(first);
		random_byte(partial);
		start_frame();
		send_bits(8'd2, 8);
		send_bits(8'd1, 8);
		send_bits(first, 8);
		send_bits(partial, 4);
		end_frame();
		model[2][1] = first;
		random_byte(b);
		data.push_back(b);
		write_strip(2, 3, data);
		flush_and_compare("abort");
	endtask

	initial begin
		value_errors = 0;
		timeout_errors = 0;
		timing_errors = 0;
		lfsr = 32'hf875;
		reset = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		cs = 1'b0;
		repeat (4) @(negedge clk);
		// a cs pulse clears the sclk-domain shifter
		cs = 1'b1;
		@(negedge clk);
		cs = 1'b0;
		repeat (11) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		reset_state();
		write_and_flush();
		offset_increment();
		invalid_command();
		aborted_frame();

		$display("errors: %0d value mismatches, %0d timeouts, %0d latch gap errors",
			value_errors, timeout_errors, timing_errors);
		if (value_errors == 0 && timeout_errors == 0 && timing_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== neopixel_properties.sv ====
`timescale 1ns/1ps

module neopixel_properties
	import neopixel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic pixel,
	input logic busy
);

	int high_count;

	// consecutive cycles the pixel pin was sampled high
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			high_count <= 0;
		else if (pixel)
			high_count <= high_count + 1;
		else
			high_count <= 0;
	end

	pixel_low_while_idle: assert property (
		@(posedge clk) disable iff (reset) !busy |-> !pixel
	) else $error("pixel is high while the strip is idle");

	busy_follows_flush: assert property (
		@(posedge clk) disable iff (reset) $rose(busy) |-> $past(flush)
	) else $error("busy rose without a flush on the previous cycle");

	pulse_width_limit: assert property (
		@(posedge clk) disable iff (reset) high_count <= T1_HIGH
	) else $error("pixel high pulse is longer than a one bit");

endmodule

bind strip_controller neopixel_properties i_neopixel_properties (
	.clk  (clk),
	.reset(reset),
	.flush(flush),
	.pixel(pixel),
	.busy (busy)
);

// ==== neopixel_driver.sv ====
`timescale 1ns/1ps

module neopixel_driver
	import neopixel_pkg::*;
#(
	parameter int NUM_STRIPS   = 24,
	parameter int STRIP_BYTES  = 75,
	parameter int LATCH_CYCLES = 2000
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sclk,
	input  logic                  mosi,
	input  logic                  cs,
	output logic [NUM_STRIPS-1:0] pixels,
	output logic                  flushing
);

	byte_t byte_data, write_data;
	addr_t write_addr;
	logic byte_done, cs_sync, flush;
	logic [NUM_STRIPS-1:0] strip_write;
	logic [NUM_STRIPS-1:0] strip_busy;

	spi_byte_receiver i_spi_byte_receiver (
		.clk      (clk),
		.reset    (reset),
		.sclk     (sclk),
		.mosi     (mosi),
		.cs       (cs),
		.byte_data(byte_data),
		.byte_done(byte_done),
		.cs_sync  (cs_sync)
	);

	spi_command_decoder #(
		.NUM_STRIPS(NUM_STRIPS)
	) i_spi_command_decoder (
		.clk        (clk),
		.reset      (reset),
		.byte_done  (byte_done),
		.cs_sync    (cs_sync),
		.byte_data  (byte_data),
		.write_data (write_data),
		.write_addr (write_addr),
		.strip_write(strip_write),
		.flush      (flush)
	);

	for (genvar i = 0; i < NUM_STRIPS; i++) begin : g_strip
		strip_controller #(
			.STRIP_BYTES (STRIP_BYTES),
			.LATCH_CYCLES(LATCH_CYCLES)
		) i_strip_controller (
			.clk       (clk),
			.reset     (reset),
			.write_en  (strip_write[i]),
			.flush     (flush),
			.write_data(write_data),
			.write_addr(write_addr),
			.pixel     (pixels[i]),
			.busy      (strip_busy[i])
		);
	end

	assign flushing = |strip_busy;

endmodule

// ==== spi_command_decoder.sv ====
`timescale 1ns/1ps

module spi_command_decoder
	import neopixel_pkg::*;
#(
	parameter int NUM_STRIPS = 24
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  byte_done,
	input  logic                  cs_sync,
	input  byte_t                 byte_data,
	output byte_t                 write_data,
	output addr_t                 write_addr,
	output logic [NUM_STRIPS-1:0] strip_write,
	output logic                  flush
);

	cmd_state_t state, next_state;
	byte_t strip_sel;
	addr_t offset;
	logic write_cycle;

	always_comb begin
		next_state = state;
		if (byte_done) begin
			case (state)
				DEC_IDLE: begin
					if (byte_data < NUM_STRIPS)
						next_state = DEC_READ_OFFSET;
					else
						next_state = DEC_FLUSH;
				end
				DEC_READ_OFFSET: next_state = DEC_READ_DATA;
				DEC_READ_DATA: next_state = DEC_READ_DATA;
				DEC_FLUSH: next_state = DEC_FLUSH;
				default: next_state = DEC_IDLE;
			endcase
		end
	end

	// a frame ends only when chip select drops
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			state <= DEC_IDLE;
		else if (!cs_sync)
			state <= DEC_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			strip_sel <= '0;
			offset <= '0;
		end else if (byte_done) begin
			if (state == DEC_IDLE)
				strip_sel <= byte_data;
			if (state == DEC_READ_OFFSET)
				offset <= byte_data;
			else if (state == DEC_READ_DATA)
				offset <= offset + 8'd1;
		end
	end

	assign write_data = byte_data;
	assign write_addr = offset;

	assign write_cycle = byte_done && (state == DEC_READ_DATA);
	assign flush = byte_done && (state == DEC_IDLE) && (byte_data == CMD_FLUSH);

	always_comb begin
		for (int i = 0; i < NUM_STRIPS; i++)
			strip_write[i] = write_cycle && (strip_sel == 8'(i));
	end

endmodule

// ==== spi_byte_receiver.sv ====
`timescale 1ns/1ps

module spi_byte_receiver
	import neopixel_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  sclk,
	input  logic  mosi,
	input  logic  cs,
	output byte_t byte_data,
	output logic  byte_done,
	output logic  cs_sync
);

	byte_t sclk_shift;
	logic [2:0] sclk_count;

	byte_t data_s1, data_s2;
	logic [2:0] count_s1, count_s2, count_s3;
	logic cs_s1;
	logic wrap;

	// sclk domain is held clear while the chip is deselected
	always_ff @(posedge sclk, negedge cs) begin
		if (!cs) begin
			sclk_shift <= '0;
			sclk_count <= '0;
		end else begin
			sclk_shift <= {sclk_shift[6:0], mosi};
			sclk_count <= sclk_count + 3'd1;
		end
	end

	// one byte is complete when the bit count wraps from 7 to 0
	assign wrap = (count_s3 == 3'd7) && (count_s2 == 3'd0);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			data_s1 <= '0;
			data_s2 <= '0;
			count_s1 <= '0;
			count_s2 <= '0;
			count_s3 <= '0;
			cs_s1 <= 1'b0;
			cs_sync <= 1'b0;
			byte_data <= '0;
			byte_done <= 1'b0;
		end else begin
			data_s1 <= sclk_shift;
			data_s2 <= data_s1;
			count_s1 <= sclk_count;
			count_s2 <= count_s1;
			count_s3 <= count_s2;
			cs_s1 <= cs;
			cs_sync <= cs_s1;
			byte_done <= wrap;
			if (wrap)
				byte_data <= data_s2;
		end
	end

endmodule

// ==== strip_controller.sv ====
`timescale 1ns/1ps

module strip_controller
	import neopixel_pkg::*;
#(
	parameter int STRIP_BYTES  = 75,
	parameter int LATCH_CYCLES = 2000
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  write_en,
	input  logic  flush,
	input  byte_t write_data,
	input  addr_t write_addr,
	output logic  pixel,
	output logic  busy
);

	localparam int LATCH_W = $clog2(LATCH_CYCLES + 1);

	byte_t mem [256];
	byte_t read_data;
	addr_t read_addr, read_addr_next;

	strip_state_t state, next_state;
	logic [LATCH_W-1:0] latch_count;
	logic ser_start, ser_done;

	// read port is fed by the next address so data is ready in SEND_START
	always_ff @(posedge clk) begin
		if (write_en)
			mem[write_addr] <= write_data;
		read_data <= mem[read_addr_next];
	end

	always_comb begin
		next_state = state;
		read_addr_next = read_addr;
		case (state)
			LOADING: begin
				if (flush) begin
					next_state = SEND_START;
					read_addr_next = '0;
				end
			end
			SEND_START: next_state = SEND_WAIT;
			SEND_WAIT: begin
				if (ser_done) begin
					if (read_addr == addr_t'(STRIP_BYTES - 1)) begin
						next_state = LATCH;
					end else begin
						next_state = SEND_START;
						read_addr_next = read_addr + 8'd1;
					end
				end
			end
			LATCH: begin
				if (latch_count == LATCH_W'(LATCH_CYCLES - 1))
					next_state = LOADING;
			end
			default: next_state = LOADING;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= LOADING;
			read_addr <= '0;
			latch_count <= '0;
		end else begin
			state <= next_state;
			read_addr <= read_addr_next;
			if (state == LATCH)
				latch_count <= latch_count + 1'b1;
			else
				latch_count <= '0;
		end
	end

	assign ser_start = (state == SEND_START);
	assign busy = (state != LOADING);

	byte_serializer i_byte_serializer (
		.clk   (clk),
		.reset (reset),
		.start (ser_start),
		.data  (read_data),
		.serial(pixel),
		.done  (ser_done)
	);

endmodule

// ==== byte_serializer.sv ====
`timescale 1ns/1ps

module byte_serializer
	import neopixel_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  start,
	input  byte_t data,
	output logic  serial,
	output logic  done
);

	ser_state_t state;
	byte_t data_q;
	logic [2:0] bit_idx;
	logic bit_start, bit_done;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= SER_IDLE;
			data_q <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (start) begin
						data_q <= data;
						bit_idx <= '0;
						state <= SER_BIT_START;
					end
				end
				SER_BIT_START: state <= SER_BIT_WAIT;
				SER_BIT_WAIT: begin
					// encoder is back to idle once the slot has ended
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state <= SER_IDLE;
						end else begin
							bit_idx <= bit_idx + 3'd1;
							state <= SER_BIT_START;
						end
					end
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

	assign bit_start = (state == SER_BIT_START);
	assign done = (state == SER_IDLE);

	ws2812_bit_encoder i_ws2812_bit_encoder (
		.clk      (clk),
		.reset    (reset),
		.start    (bit_start),
		.bit_value(data_q[bit_idx]),
		.serial   (serial),
		.done     (bit_done)
	);

endmodule

// ==== ws2812_bit_encoder.sv ====
`timescale 1ns/1ps

module ws2812_bit_encoder
	import neopixel_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic bit_value,
	output logic serial,
	output logic done
);

	localparam int CNT_W = $clog2(BIT_CYCLES);

	bit_state_t state;
	logic [CNT_W-1:0] slot_count;
	logic value_q;
	logic [CNT_W-1:0] high_width;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= BIT_IDLE;
			slot_count <= '0;
			value_q <= 1'b0;
		end else if (state == BIT_IDLE) begin
			if (start) begin
				state <= BIT_DRIVE;
				slot_count <= '0;
				value_q <= bit_value;
			end
		end else begin
			slot_count <= slot_count + 1'b1;
			if (slot_count == CNT_W'(BIT_CYCLES - 1))
				state <= BIT_IDLE;
		end
	end

	assign high_width = value_q ? CNT_W'(T1_HIGH) : CNT_W'(T0_HIGH);

	// high first, then low for the rest of the slot
	assign serial = (state == BIT_DRIVE) && (slot_count < high_width);
	assign done = (state == BIT_IDLE);

endmodule

// ==== neopixel_pkg.sv ====
package neopixel_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] addr_t;

	// DEC_FLUSH also swallows the rest of a frame with an unknown command
	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_FLUSH,
		DEC_READ_OFFSET,
		DEC_READ_DATA
	} cmd_state_t;

	typedef enum logic [1:0] {
		LOADING,
		SEND_START,
		SEND_WAIT,
		LATCH
	} strip_state_t;

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_BIT_START,
		SER_BIT_WAIT
	} ser_state_t;

	typedef enum logic {
		BIT_IDLE,
		BIT_DRIVE
	} bit_state_t;

	localparam byte_t CMD_FLUSH = 8'h46;

	// WS2812 bit timing in clk cycles at 40 MHz
	localparam int BIT_CYCLES = 50;
	localparam int T1_HIGH = 32;
	localparam int T0_HIGH = 16;

endpackage
